//--- afs_pkg.sv
/*
 * Shared definitions for the flower-shop inventory controller
 *   sizes of stock counts and the record store
 *   flower, action, mode, warning, date and record types
 *   demand table per strategy and mode, and the demand lookup function
 */
package afs_pkg;

    // ==================================================
    // Sizes
    // ==================================================
    localparam int NUM_FLOWERS = 4;
    localparam int STOCK_W     = 12;
    localparam int STOCK_MAX   = 4095;
    localparam int NUM_RECORDS = 256;
    localparam int REC_ADDR_W  = 8;

    // ==================================================
    // Types
    // ==================================================
    typedef enum logic [1:0] {
        ROSE        = 2'd0,
        LILY        = 2'd1,
        CARNATION   = 2'd2,
        BABY_BREATH = 2'd3
    } flower_e;

    typedef logic [STOCK_W-1:0] stock_t;

    // Index 0 (rose) sits in the upper bits
    typedef stock_t [0:NUM_FLOWERS-1] stock_vec_t;

    typedef logic [3:0] month_t;
    typedef logic [4:0] day_t;

    // Month above day, so dates order as plain unsigned values
    typedef struct packed {
        month_t month;
        day_t   day;
    } date_t;

    typedef struct packed {
        stock_vec_t stock;
        date_t      expiry;
    } record_t;

    typedef enum logic [1:0] {
        PURCHASE         = 2'd0,
        RESTOCK          = 2'd1,
        CHECK_VALID_DATE = 2'd2
    } action_e;

    typedef enum logic [1:0] {
        SINGLE      = 2'b00,
        GROUP_ORDER = 2'b01,
        EVENT       = 2'b11
    } mode_e;

    typedef logic [2:0] strategy_t;

    typedef enum logic [1:0] {
        NO_WARN      = 2'd0,
        DATE_WARN    = 2'd1,
        STOCK_WARN   = 2'd2,
        RESTOCK_WARN = 2'd3
    } warn_e;

    // ==================================================
    // Demand table, indexed single / group order / event
    // ==================================================
    localparam stock_t [0:2] DEMAND_SINGLE = {12'd120, 12'd480, 12'd960};
    localparam stock_t [0:2] DEMAND_PAIR   = {12'd60, 12'd240, 12'd480};
    localparam stock_t [0:2] DEMAND_ALL    = {12'd30, 12'd120, 12'd240};

    function automatic stock_vec_t demand_for(strategy_t strategy, mode_e mode);
        int unsigned m_idx;
        stock_vec_t  dem;
        case (mode)
            SINGLE:      m_idx = 0;
            GROUP_ORDER: m_idx = 1;
            default:     m_idx = 2;
        endcase
        dem = '0;
        case (strategy)
            3'd4: begin
                dem[ROSE] = DEMAND_PAIR[m_idx];
                dem[LILY] = DEMAND_PAIR[m_idx];
            end
            3'd5: begin
                dem[CARNATION]   = DEMAND_PAIR[m_idx];
                dem[BABY_BREATH] = DEMAND_PAIR[m_idx];
            end
            3'd6: begin
                dem[ROSE]      = DEMAND_PAIR[m_idx];
                dem[CARNATION] = DEMAND_PAIR[m_idx];
            end
            3'd7: dem = {NUM_FLOWERS{DEMAND_ALL[m_idx]}};
            // Strategies 0 to 3 pick one kind in flower order
            default: dem[flower_e'(strategy[1:0])] = DEMAND_SINGLE[m_idx];
        endcase
        return dem;
    endfunction

endpackage

//--- order_req_if.sv
/*
 * Request bus from the field capture stage to the order engine
 *   one-cycle req_valid pulse, fields held until the next action
 *   source and sink modports
 */
`timescale 1ns/1ps

interface order_req_if import afs_pkg::*; ();

    logic                  req_valid;
    action_e               action;
    date_t                 today;
    logic [REC_ADDR_W-1:0] rec_addr;
    // Demand for a purchase, added amounts for a restock
    stock_vec_t            amounts;

    modport source (
        output req_valid,
        output action,
        output today,
        output rec_addr,
        output amounts
    );

    modport sink (
        input req_valid,
        input action,
        input today,
        input rec_addr,
        input amounts
    );

endinterface

//--- record_port_if.sv
/*
 * Record store port
 *   registered read with one cycle of latency
 *   synchronous write
 *   master and store modports
 */
`timescale 1ns/1ps

interface record_port_if import afs_pkg::*; ();

    logic                  rd_en;
    logic [REC_ADDR_W-1:0] rd_addr;
    record_t               rd_data;
    logic                  wr_en;
    logic [REC_ADDR_W-1:0] wr_addr;
    record_t               wr_data;

    modport master (
        output rd_en,
        output rd_addr,
        input  rd_data,
        output wr_en,
        output wr_addr,
        output wr_data
    );

    modport store (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        input  wr_en,
        input  wr_addr,
        input  wr_data
    );

endinterface

//--- afs_request_capture.sv
/*
 * Field capture stage
 *   registers action, strategy, mode, date and record number
 *   collects the four restock beats in flower order
 *   resolves purchase demand and pulses the request on the last field
 */
`timescale 1ns/1ps

module afs_request_capture import afs_pkg::*; (
    input  logic                  clk,
    input  logic                  inf,
    input  logic                  sel_action_valid,
    input  action_e               action,
    input  logic                  strategy_valid,
    input  strategy_t             strategy,
    input  logic                  mode_valid,
    input  mode_e                 mode,
    input  logic                  date_valid,
    input  month_t                month,
    input  day_t                  day,
    input  logic                  data_no_valid,
    input  logic [REC_ADDR_W-1:0] data_no,
    input  logic                  restock_valid,
    input  stock_t                stock,
    order_req_if.source           req
);

    logic [1:0] beat_cnt;
    strategy_t  strategy_q;
    mode_e      mode_q;
    logic       last_field;

    // data_no closes purchase and check, the fourth stock beat closes restock
    assign last_field = (data_no_valid && req.action != RESTOCK) ||
                        (restock_valid && beat_cnt == 2'(NUM_FLOWERS - 1));

    // ==================================================
    // Control
    // ==================================================
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            req.req_valid <= 1'b0;
            req.action    <= PURCHASE;
            beat_cnt      <= '0;
        end else begin
            req.req_valid <= last_field;
            if (sel_action_valid) begin
                req.action <= action;
                beat_cnt   <= '0;
            end else if (restock_valid) begin
                beat_cnt <= beat_cnt + 2'd1;
            end
        end
    end

    // ==================================================
    // Payload fields
    // ==================================================
    always_ff @(posedge clk) begin
        if (strategy_valid) begin
            strategy_q <= strategy;
        end
        if (mode_valid) begin
            mode_q <= mode;
        end
        if (date_valid) begin
            req.today.month <= month;
            req.today.day   <= day;
        end
        if (data_no_valid) begin
            req.rec_addr <= data_no;
        end
        // Restock beats land in flower order
        if (restock_valid) begin
            req.amounts[beat_cnt] <= stock;
        end else if (data_no_valid && req.action == PURCHASE) begin
            req.amounts <= demand_for(strategy_q, mode_q);
        end
    end

endmodule

//--- inventory_store.sv
/*
 * Inventory record store
 *   NUM_RECORDS records of four stock counts and an expiry date
 *   registered read, synchronous write, all records cleared on reset
 */
`timescale 1ns/1ps

module inventory_store import afs_pkg::*; (
    input  logic         clk,
    input  logic         inf,
    record_port_if.store port
);

    record_t mem_q [NUM_RECORDS];

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            for (int i = 0; i < NUM_RECORDS; i++) begin
                mem_q[i] <= '0;
            end
            port.rd_data <= '0;
        end else begin
            if (port.wr_en) begin
                mem_q[port.wr_addr] <= port.wr_data;
            end
            // Read data holds until the next read
            if (port.rd_en) begin
                port.rd_data <= mem_q[port.rd_addr];
            end
        end
    end

endmodule

//--- afs_order_engine.sv
/*
 * Order engine
 *   FSM idle, read, evaluate, write, report
 *   date, stock and restock warnings, stock update and write back
 *   one-cycle result with out_valid, warn_msg and complete
 */
`timescale 1ns/1ps

module afs_order_engine import afs_pkg::*; (
    input  logic          clk,
    input  logic          inf,
    order_req_if.sink     req,
    record_port_if.master mem,
    output logic          out_valid,
    output warn_e         warn_msg,
    output logic          complete
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_EVAL,
        ST_WRITE,
        ST_REPORT
    } state_e;

    state_e                   state_q;
    state_e                   state_d;
    warn_e                    warn_q;
    record_t                  wr_rec_q;
    logic [NUM_FLOWERS-1:0]   short_flags;
    logic [NUM_FLOWERS-1:0]   sat_flags;
    stock_vec_t               left_stock;
    stock_vec_t               added_stock;
    logic [STOCK_W:0]         sum;
    logic                     date_early;
    warn_e                    eval_warn;
    record_t                  eval_rec;
    logic                     eval_write;

    // ==================================================
    // Evaluate
    // ==================================================
    assign date_early = req.today < mem.rd_data.expiry;

    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_FLOWERS; i++) begin
            short_flags[i] = mem.rd_data.stock[i] < req.amounts[i];
            left_stock[i]  = mem.rd_data.stock[i] - req.amounts[i];
            sum            = {1'b0, mem.rd_data.stock[i]} + {1'b0, req.amounts[i]};
            sat_flags[i]   = sum[STOCK_W];
            added_stock[i] = sum[STOCK_W] ? stock_t'(STOCK_MAX) : sum[STOCK_W-1:0];
        end
    end

    // Date warning outranks stock warning
    always_comb begin
        eval_warn  = NO_WARN;
        eval_rec   = mem.rd_data;
        eval_write = 1'b0;
        case (req.action)
            PURCHASE: begin
                if (date_early) begin
                    eval_warn = DATE_WARN;
                end else if (|short_flags) begin
                    eval_warn = STOCK_WARN;
                end else begin
                    eval_rec.stock = left_stock;
                    eval_write     = 1'b1;
                end
            end
            RESTOCK: begin
                eval_rec.stock  = added_stock;
                eval_rec.expiry = req.today;
                eval_write      = 1'b1;
                if (|sat_flags) begin
                    eval_warn = RESTOCK_WARN;
                end
            end
            CHECK_VALID_DATE: begin
                if (date_early) begin
                    eval_warn = DATE_WARN;
                end
            end
            default: eval_warn = NO_WARN;
        endcase
    end

    // ==================================================
    // FSM
    // ==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:   if (req.req_valid) state_d = ST_READ;
            ST_READ:   state_d = ST_EVAL;
            ST_EVAL:   state_d = eval_write ? ST_WRITE : ST_REPORT;
            ST_WRITE:  state_d = ST_REPORT;
            ST_REPORT: state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state_q <= ST_IDLE;
            warn_q  <= NO_WARN;
        end else begin
            state_q <= state_d;
            if (state_q == ST_EVAL) begin
                warn_q <= eval_warn;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_EVAL) begin
            wr_rec_q <= eval_rec;
        end
    end

    // Store port
    assign mem.rd_en   = state_q == ST_READ;
    assign mem.rd_addr = req.rec_addr;
    assign mem.wr_en   = state_q == ST_WRITE;
    assign mem.wr_addr = req.rec_addr;
    assign mem.wr_data = wr_rec_q;

    // Result beat
    assign out_valid = state_q == ST_REPORT;
    assign warn_msg  = out_valid ? warn_q : NO_WARN;
    assign complete  = out_valid && warn_q == NO_WARN;

endmodule

//--- afs.sv
/*
 * Flower-shop inventory controller, top level
 *   field capture, order engine and record store
 *   request and record buses between them
 */
`timescale 1ns/1ps

module afs import afs_pkg::*; (
    input  logic                  clk,
    input  logic                  inf,
    input  logic                  sel_action_valid,
    input  action_e               action,
    input  logic                  strategy_valid,
    input  strategy_t             strategy,
    input  logic                  mode_valid,
    input  mode_e                 mode,
    input  logic                  date_valid,
    input  month_t                month,
    input  day_t                  day,
    input  logic                  data_no_valid,
    input  logic [REC_ADDR_W-1:0] data_no,
    input  logic                  restock_valid,
    input  stock_t                stock,
    output logic                  out_valid,
    output warn_e                 warn_msg,
    output logic                  complete
);

    order_req_if   req_bus ();
    record_port_if rec_bus ();

    afs_request_capture capture_inst (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .action           (action),
        .strategy_valid   (strategy_valid),
        .strategy         (strategy),
        .mode_valid       (mode_valid),
        .mode             (mode),
        .date_valid       (date_valid),
        .month            (month),
        .day              (day),
        .data_no_valid    (data_no_valid),
        .data_no          (data_no),
        .restock_valid    (restock_valid),
        .stock            (stock),
        .req              (req_bus.source)
    );

    afs_order_engine engine_inst (
        .clk       (clk),
        .inf       (inf),
        .req       (req_bus.sink),
        .mem       (rec_bus.master),
        .out_valid (out_valid),
        .warn_msg  (warn_msg),
        .complete  (complete)
    );

    inventory_store store_inst (
        .clk  (clk),
        .inf  (inf),
        .port (rec_bus.store)
    );

endmodule

//--- afs_assertions.sv
/*
 * Concurrent checks on the controller top level
 *   single-cycle out_valid, complete only on a clean result
 *   quiet warn_msg between results, no read and write in one cycle
 */
`timescale 1ns/1ps

module afs_assertions import afs_pkg::*; (
    input logic  clk,
    input logic  inf,
    input logic  out_valid,
    input warn_e warn_msg,
    input logic  complete,
    input logic  rd_en,
    input logic  wr_en
);

    out_valid_pulse: assert property (@(posedge clk) disable iff (!inf)
        out_valid |=> !out_valid)
        else $error("out_valid held high for more than one cycle");

    complete_clean: assert property (@(posedge clk) disable iff (!inf)
        complete |-> (out_valid && warn_msg == NO_WARN))
        else $error("complete high without a clean result beat");

    warn_quiet: assert property (@(posedge clk) disable iff (!inf)
        !out_valid |-> warn_msg == NO_WARN)
        else $error("warn_msg active outside a result beat");

    // Store port is read or written, never both
    port_exclusive: assert property (@(posedge clk) disable iff (!inf)
        !(rd_en && wr_en))
        else $error("record store read and written in the same cycle");

endmodule

bind afs afs_assertions assertions_inst (
    .clk       (clk),
    .inf       (inf),
    .out_valid (out_valid),
    .warn_msg  (warn_msg),
    .complete  (complete),
    .rd_en     (rec_bus.rd_en),
    .wr_en     (rec_bus.wr_en)
);

//--- tb_afs.sv
/*
 * Testbench for the flower-shop inventory controller
 *   clock, reset and field stimulus on the falling edge
 *   record model with its own demand table
 *   directed tests, a random mix, compare task, watchdog and summary
 */
`timescale 1ns/1ps

module tb_afs import afs_pkg::*; ();

    localparam int          NUM_RANDOM   = 200;
    localparam int          MAX_ACTIONS  = 240;
    localparam int          RESET_CYCLES = 16;
    localparam int          RESULT_WAIT  = 8;
    localparam int unsigned SEED         = 32'h7e4e;

    typedef enum int {F_ACTION, F_STRATEGY, F_MODE, F_DATE, F_DATA_NO, F_STOCK} field_e;

    logic                  clk;
    logic                  inf;
    logic                  sel_action_valid;
    action_e               action;
    logic                  strategy_valid;
    strategy_t             strategy;
    logic                  mode_valid;
    mode_e                 mode;
    logic                  date_valid;
    month_t                month;
    day_t                  day;
    logic                  data_no_valid;
    logic [REC_ADDR_W-1:0] data_no;
    logic                  restock_valid;
    stock_t                stock;
    logic                  out_valid;
    warn_e                 warn_msg;
    logic                  complete;

    record_t model_q [NUM_RECORDS];
    int      check_cnt;
    int      err_cnt;
    int      test_cnt;
    int      test_errs;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    afs afs_inst (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .action           (action),
        .strategy_valid   (strategy_valid),
        .strategy         (strategy),
        .mode_valid       (mode_valid),
        .mode             (mode),
        .date_valid       (date_valid),
        .month            (month),
        .day              (day),
        .data_no_valid    (data_no_valid),
        .data_no          (data_no),
        .restock_valid    (restock_valid),
        .stock            (stock),
        .out_valid        (out_valid),
        .warn_msg         (warn_msg),
        .complete         (complete)
    );

    // ==================================================
    // Helpers
    // ==================================================
    task automatic check_value(input string name, input int expected, input int actual);
        check_cnt++;
        if (expected != actual) begin
            err_cnt++;
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic clear_valids();
        sel_action_valid = 1'b0;
        strategy_valid   = 1'b0;
        mode_valid       = 1'b0;
        date_valid       = 1'b0;
        data_no_valid    = 1'b0;
        restock_valid    = 1'b0;
    endtask

    function automatic date_t make_date(input month_t m, input day_t d);
        date_t dt;
        dt.month = m;
        dt.day   = d;
        return dt;
    endfunction

    function automatic stock_vec_t stock_vec(input stock_t r, input stock_t l,
                                             input stock_t c, input stock_t b);
        stock_vec_t v;
        v[0] = r;
        v[1] = l;
        v[2] = c;
        v[3] = b;
        return v;
    endfunction

    function automatic bit date_before(input date_t a, input date_t b);
        return (a.month < b.month) || (a.month == b.month && a.day < b.day);
    endfunction

    // Single 120 per kind, pair 60, all 30; group order x4, event x8
    function automatic stock_vec_t model_demand(input strategy_t strat, input mode_e md);
        int         scale;
        int         base;
        logic [3:0] kinds;
        stock_vec_t dem;
        case (md)
            SINGLE:      scale = 1;
            GROUP_ORDER: scale = 4;
            default:     scale = 8;
        endcase
        // Bit i of kinds is flower i
        case (strat)
            3'd4: begin
                kinds = 4'b0011;
                base  = 60;
            end
            3'd5: begin
                kinds = 4'b1100;
                base  = 60;
            end
            3'd6: begin
                kinds = 4'b0101;
                base  = 60;
            end
            3'd7: begin
                kinds = 4'b1111;
                base  = 30;
            end
            default: begin
                kinds = 4'b0001 << strat[1:0];
                base  = 120;
            end
        endcase
        for (int i = 0; i < NUM_FLOWERS; i++) begin
            dem[i] = kinds[i] ? stock_t'(base * scale) : stock_t'(0);
        end
        return dem;
    endfunction

    task automatic send_field(input field_e kind, input logic [11:0] value);
        int gap;
        gap = int'($urandom_range(0, 2));
        repeat (gap) @(negedge clk);
        case (kind)
            F_ACTION: begin
                sel_action_valid = 1'b1;
                action           = action_e'(value[1:0]);
            end
            F_STRATEGY: begin
                strategy_valid = 1'b1;
                strategy       = value[2:0];
            end
            F_MODE: begin
                mode_valid = 1'b1;
                mode       = mode_e'(value[1:0]);
            end
            F_DATE: begin
                date_valid = 1'b1;
                month      = value[8:5];
                day        = value[4:0];
            end
            F_DATA_NO: begin
                data_no_valid = 1'b1;
                data_no       = value[7:0];
            end
            default: begin
                restock_valid = 1'b1;
                stock         = value;
            end
        endcase
        @(negedge clk);
        clear_valids();
    endtask

    // ==================================================
    // One action: model update, fields, result check
    // ==================================================
    task automatic run_action(input string name, input action_e act, input strategy_t strat,
                              input mode_e md, input date_t today,
                              input logic [REC_ADDR_W-1:0] addr, input stock_vec_t amt);
        record_t    rec;
        stock_vec_t dem;
        warn_e      exp_warn;
        int         sum;
        bit         seen;
        rec      = model_q[addr];
        exp_warn = NO_WARN;
        dem      = model_demand(strat, md);
        case (act)
            PURCHASE: begin
                if (date_before(today, rec.expiry)) begin
                    exp_warn = DATE_WARN;
                end else begin
                    for (int i = 0; i < NUM_FLOWERS; i++) begin
                        if (rec.stock[i] < dem[i]) exp_warn = STOCK_WARN;
                    end
                    if (exp_warn == NO_WARN) begin
                        for (int i = 0; i < NUM_FLOWERS; i++) rec.stock[i] -= dem[i];
                    end
                end
            end
            RESTOCK: begin
                for (int i = 0; i < NUM_FLOWERS; i++) begin
                    sum = int'(rec.stock[i]) + int'(amt[i]);
                    if (sum > STOCK_MAX) begin
                        sum      = STOCK_MAX;
                        exp_warn = RESTOCK_WARN;
                    end
                    rec.stock[i] = stock_t'(sum);
                end
                rec.expiry = today;
            end
            default: begin
                if (date_before(today, rec.expiry)) exp_warn = DATE_WARN;
            end
        endcase
        model_q[addr] = rec;

        send_field(F_ACTION, {10'd0, act});
        if (act == PURCHASE) begin
            send_field(F_STRATEGY, {9'd0, strat});
            send_field(F_MODE, {10'd0, md});
        end
        send_field(F_DATE, {3'd0, today});
        send_field(F_DATA_NO, {4'd0, addr});
        if (act == RESTOCK) begin
            for (int i = 0; i < NUM_FLOWERS; i++) send_field(F_STOCK, amt[i]);
        end

        seen = 1'b0;
        for (int c = 0; c <= RESULT_WAIT; c++) begin
            if (out_valid) begin
                seen = 1'b1;
                break;
            end
            @(negedge clk);
        end
        if (!seen) begin
            err_cnt++;
            $display("ERROR %s: no result within %0d cycles of the last field",
                     name, RESULT_WAIT);
        end else begin
            check_value({name, " warn_msg"}, int'(exp_warn), int'(warn_msg));
            check_value({name, " complete"}, int'(exp_warn == NO_WARN), int'(complete));
        end
    endtask

    task automatic start_test();
        test_errs = err_cnt;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (err_cnt == test_errs) $display("[done] %s: ok", name);
        else $display("[done] %s: %0d errors", name, err_cnt - test_errs);
    endtask

    // Watchdog
    initial begin
        repeat (MAX_ACTIONS * 40 + RESET_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        action_e     act;
        mode_e       md;
        stock_vec_t  amt;
        void'($urandom(SEED));
        check_cnt = 0;
        err_cnt   = 0;
        test_cnt  = 0;
        test_errs = 0;
        inf       = 1'b0;
        action    = PURCHASE;
        strategy  = '0;
        mode      = SINGLE;
        month     = '0;
        day       = '0;
        data_no   = '0;
        stock     = '0;
        clear_valids();
        for (int i = 0; i < NUM_RECORDS; i++) model_q[i] = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        inf = 1'b1;
        @(negedge clk);

        start_test();
        run_action("fresh restock", RESTOCK, 3'd0, SINGLE, make_date(4'd3, 5'd10), 8'd1,
                   stock_vec(12'd240, 12'd240, 12'd240, 12'd240));
        run_action("fresh buy all", PURCHASE, 3'd7, EVENT, make_date(4'd3, 5'd10), 8'd1, '0);
        run_action("fresh buy empty", PURCHASE, 3'd7, SINGLE, make_date(4'd3, 5'd10), 8'd1, '0);
        finish_test("restock_fresh");

        start_test();
        run_action("ovf base", RESTOCK, 3'd0, SINGLE, make_date(4'd2, 5'd1), 8'd2,
                   stock_vec(12'd4000, 12'd100, 12'd4000, 12'd0));
        run_action("ovf sat", RESTOCK, 3'd0, SINGLE, make_date(4'd2, 5'd2), 8'd2,
                   stock_vec(12'd200, 12'd50, 12'd95, 12'd10));
        for (int n = 0; n < 5; n++) begin
            run_action($sformatf("ovf buy %0d", n), PURCHASE, 3'd0, EVENT,
                       make_date(4'd2, 5'd2), 8'd2, '0);
        end
        finish_test("restock_overflow");

        start_test();
        run_action("ok restock", RESTOCK, 3'd0, SINGLE, make_date(4'd5, 5'd5), 8'd3,
                   stock_vec(12'd1000, 12'd1000, 12'd1000, 12'd1000));
        run_action("ok s4", PURCHASE, 3'd4, GROUP_ORDER, make_date(4'd5, 5'd5), 8'd3, '0);
        run_action("ok s5", PURCHASE, 3'd5, GROUP_ORDER, make_date(4'd6, 5'd1), 8'd3, '0);
        run_action("ok s6", PURCHASE, 3'd6, EVENT, make_date(4'd6, 5'd1), 8'd3, '0);
        run_action("ok s2", PURCHASE, 3'd2, SINGLE, make_date(4'd12, 5'd31), 8'd3, '0);
        run_action("ok drained", PURCHASE, 3'd7, EVENT, make_date(4'd12, 5'd31), 8'd3, '0);
        finish_test("purchase_ok");

        start_test();
        run_action("early restock", RESTOCK, 3'd0, SINGLE, make_date(4'd7, 5'd15), 8'd4,
                   stock_vec(12'd500, 12'd500, 12'd500, 12'd500));
        run_action("early buy", PURCHASE, 3'd7, SINGLE, make_date(4'd7, 5'd14), 8'd4, '0);
        run_action("early short", PURCHASE, 3'd3, EVENT, make_date(4'd7, 5'd1), 8'd4, '0);
        run_action("early check", CHECK_VALID_DATE, 3'd0, SINGLE, make_date(4'd6, 5'd30),
                   8'd4, '0);
        run_action("same check", CHECK_VALID_DATE, 3'd0, SINGLE, make_date(4'd7, 5'd15),
                   8'd4, '0);
        run_action("late buy", PURCHASE, 3'd3, GROUP_ORDER, make_date(4'd8, 5'd1), 8'd4, '0);
        finish_test("date_early");

        start_test();
        run_action("short restock", RESTOCK, 3'd0, SINGLE, make_date(4'd1, 5'd1), 8'd5,
                   stock_vec(12'd100, 12'd0, 12'd0, 12'd0));
        run_action("short rose", PURCHASE, 3'd0, SINGLE, make_date(4'd1, 5'd1), 8'd5, '0);
        run_action("short all", PURCHASE, 3'd7, SINGLE, make_date(4'd1, 5'd2), 8'd5, '0);
        run_action("short refill", RESTOCK, 3'd0, SINGLE, make_date(4'd1, 5'd3), 8'd5,
                   stock_vec(12'd20, 12'd30, 12'd30, 12'd30));
        run_action("refill all", PURCHASE, 3'd7, SINGLE, make_date(4'd1, 5'd3), 8'd5, '0);
        run_action("refill rose", PURCHASE, 3'd0, SINGLE, make_date(4'd1, 5'd3), 8'd5, '0);
        finish_test("stock_short");

        start_test();
        for (int n = 0; n < NUM_RANDOM; n++) begin
            act = action_e'(2'($urandom_range(0, 2)));
            case ($urandom_range(0, 2))
                0:       md = SINGLE;
                1:       md = GROUP_ORDER;
                default: md = EVENT;
            endcase
            for (int i = 0; i < NUM_FLOWERS; i++) amt[i] = stock_t'($urandom_range(0, 2500));
            run_action($sformatf("random %0d", n), act, strategy_t'($urandom_range(0, 7)), md,
                       make_date(month_t'($urandom_range(1, 12)), day_t'($urandom_range(1, 28))),
                       8'($urandom_range(0, 7)), amt);
        end
        finish_test("random_mix");

        $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
afs_pkg.sv
order_req_if.sv
record_port_if.sv
afs_request_capture.sv
inventory_store.sv
afs_order_engine.sv
afs.sv
afs_assertions.sv
tb_afs.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_afs
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
